/* run.sh */
#!/usr/bin/env bash
# build the pipeline control testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module pipeCtrlTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+src
src/pipeCtrlPkg.sv
src/hazardUnit.sv
src/fetchPort.sv
src/dataPort.sv
src/memArbiter.sv
src/sharedMem.sv
src/pipeCtrlTop.sv
tb/pipeCtrlChecker.sv
tb/pipeCtrlTb.sv

/* src/dataPort.sv */
`default_nettype none

module dataPort
    import pipeCtrlPkg::*;
(
    input  logic clk,
    input  logic rstN,
    // pipeline side
    input  logic dataReq,
    input  logic dataWe,
    input  addrT dataAddr,
    input  wordT dataWdata,
    output logic loadValid,
    output wordT loadData,
    output logic doneStore,
    output logic dWait,
    // arbiter side
    output logic reqD,
    output logic weD,
    output addrT addrD,
    output wordT wdataD,
    input  logic grantD,
    input  logic rspD,
    input  wordT rspData
);
    logic pending;
    logic granted;
    logic accept;
    logic weQ;
    addrT addrQ;
    wordT wdataQ;

    // one access at a time
    assign accept = dataReq && !pending;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= 1'b0;
            granted <= 1'b0;
        end else if (rspD) begin
            pending <= 1'b0;
            granted <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (grantD) begin
            granted <= 1'b1;
        end
    end

    // access payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            weQ    <= dataWe;
            addrQ  <= dataAddr;
            wdataQ <= dataWdata;
        end
    end

    assign reqD   = pending && !granted;
    assign weD    = weQ;
    assign addrD  = addrQ;
    assign wdataD = wdataQ;

    // response split by access kind
    assign dWait     = pending && !rspD;
    assign loadValid = rspD && !weQ;
    assign doneStore = rspD && weQ;
    assign loadData  = rspData;

    assert property (@(posedge clk) disable iff (!rstN) rspD |-> pending);

endmodule

`default_nettype wire

/* src/fetchPort.sv */
`default_nettype none

module fetchPort
    import pipeCtrlPkg::*;
(
    input  logic clk,
    input  logic rstN,
    // pipeline side
    input  logic fetchReq,
    input  addrT fetchAddr,
    output logic instrValid,
    output wordT instr,
    output logic iWait,
    // arbiter side
    output logic reqF,
    output addrT addrF,
    input  logic grantF,
    input  logic rspF,
    input  wordT rspData
);
    logic pending;
    logic granted;
    logic accept;
    addrT addrQ;

    // new strobes are dropped while a read is open
    assign accept = fetchReq && !pending;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= 1'b0;
            granted <= 1'b0;
        end else if (rspF) begin
            pending <= 1'b0;
            granted <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (grantF) begin
            granted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addrQ <= fetchAddr;
        end
    end

    // request held until the arbiter takes it
    assign reqF  = pending && !granted;
    assign addrF = addrQ;

    // wait drops in the return cycle
    assign iWait      = pending && !rspF;
    assign instrValid = rspF;
    assign instr      = rspData;

    assert property (@(posedge clk) disable iff (!rstN) rspF |-> pending);

endmodule

`default_nettype wire

/* src/hazardUnit.sv */
`default_nettype none

module hazardUnit (
    input  logic clk,
    input  logic rstN,
    input  logic branchE,
    input  logic iWait,
    input  logic dWait,
    input  logic eWait,
    input  logic branchMisalign,
    input  logic excpW,
    output logic stallF,
    output logic stallF2,
    output logic stallD,
    output logic stallE,
    output logic stallM,
    output logic stallM2,
    output logic flushF2,
    output logic flushI,
    output logic flushD,
    output logic flushE,
    output logic flushM,
    output logic flushW,
    output logic flushQue
);
    // events seen while a fetch was outstanding
    logic excpPend;
    logic branchPend;
    logic misalignPend;
    logic excpPendNxt;
    logic branchPendNxt;
    logic misalignPendNxt;

    // second mem stage is stalled elsewhere, never from here
    assign stallM2 = 1'b0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            excpPend     <= 1'b0;
            branchPend   <= 1'b0;
            misalignPend <= 1'b0;
        end else begin
            excpPend     <= excpPendNxt;
            branchPend   <= branchPendNxt;
            misalignPend <= misalignPendNxt;
        end
    end

    always_comb begin
        stallF          = 1'b0;
        stallF2         = 1'b0;
        stallD          = 1'b0;
        stallE          = 1'b0;
        stallM          = 1'b0;
        flushF2         = 1'b0;
        flushI          = 1'b0;
        flushD          = 1'b0;
        flushE          = 1'b0;
        flushM          = 1'b0;
        flushW          = 1'b0;
        flushQue        = 1'b0;
        excpPendNxt     = excpPend;
        branchPendNxt   = branchPend;
        misalignPendNxt = misalignPend;

        // priority: exception, execute, data, fetch, idle
        if (excpW) begin
            flushF2  = 1'b1;
            flushD   = 1'b1;
            flushI   = 1'b1;
            flushE   = 1'b1;
            flushM   = 1'b1;
            flushW   = 1'b1;
            flushQue = 1'b1;
            // fetch still in flight, hold pc and flush decode on return
            if (iWait) begin
                excpPendNxt = 1'b1;
                stallF      = 1'b1;
            end
        end else if (eWait) begin
            stallF  = 1'b1;
            stallF2 = 1'b1;
            stallD  = 1'b1;
            stallE  = 1'b1;
            // bubble into mem unless mem itself is busy
            if (dWait) begin
                stallM = 1'b1;
            end else begin
                flushM = 1'b1;
            end
        end else if (dWait) begin
            stallF  = 1'b1;
            stallF2 = 1'b1;
            stallD  = 1'b1;
            stallE  = 1'b1;
            stallM  = 1'b1;
        end else if (iWait) begin
            stallF = 1'b1;
            flushD = 1'b1;
            if (branchE) begin
                branchPendNxt = 1'b1;
                flushF2       = 1'b1;
                flushI        = 1'b1;
                flushE        = 1'b1;
                flushM        = 1'b1;
                flushQue      = 1'b1;
            end
            if (branchMisalign) begin
                misalignPendNxt = 1'b1;
            end
        end else begin
            // taken branch kills the younger stages
            flushF2  = branchE || branchMisalign;
            flushD   = branchE || branchMisalign;
            flushI   = branchE;
            flushE   = branchE;
            flushM   = branchE;
            flushQue = branchE;
        end

        // late fetch returned, drop the stale instruction once
        if (!iWait && excpPend) begin
            flushD      = 1'b1;
            excpPendNxt = 1'b0;
        end
        if (!iWait && branchPend) begin
            flushD        = 1'b1;
            branchPendNxt = 1'b0;
        end
        if (!iWait && misalignPend) begin
            flushD          = 1'b1;
            misalignPendNxt = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/memArbiter.sv */
`default_nettype none

module memArbiter
    import pipeCtrlPkg::*;
(
    input  logic clk,
    input  logic rstN,
    // fetch client
    input  logic reqF,
    input  addrT addrF,
    // data client
    input  logic reqD,
    input  logic weD,
    input  addrT addrD,
    input  wordT wdataD,
    // grants back to the clients
    output logic grantF,
    output logic grantD,
    // memory side
    output logic memEn,
    output logic memWe,
    output addrT memAddr,
    output wordT memWdata,
    // response strobes, one cycle after the grant
    output logic rspF,
    output logic rspD
);
    grantT owner;

    // data always wins, fetch takes the leftover cycles
    assign grantD = reqD;
    assign grantF = reqF && !reqD;

    assign memEn    = grantD || grantF;
    assign memWe    = grantD && weD;
    assign memAddr  = grantD ? addrD : addrF;
    // only the data port writes
    assign memWdata = grantD ? wdataD : '0;

    // remember who owns the read coming out next cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            owner <= GRANT_NONE;
        end else if (grantD) begin
            owner <= GRANT_DATA;
        end else if (grantF) begin
            owner <= GRANT_FETCH;
        end else begin
            owner <= GRANT_NONE;
        end
    end

    assign rspF = (owner == GRANT_FETCH);
    assign rspD = (owner == GRANT_DATA);

endmodule

`default_nettype wire

/* src/pipeCtrlPkg.sv */
`default_nettype none

`include "pipeCtrl_settings.svh"

package pipeCtrlPkg;

    // word address into the shared memory
    typedef logic [`ADDR_WIDTH-1:0] addrT;

    // one memory / instruction word
    typedef logic [`DATA_WIDTH-1:0] wordT;

    // owner of the memory cycle, kept one cycle to steer the response
    typedef enum logic [1:0] {
        GRANT_NONE  = 2'd0,
        GRANT_FETCH = 2'd1,
        GRANT_DATA  = 2'd2
    } grantT;

endpackage

`default_nettype wire

/* src/pipeCtrlTop.sv */
`default_nettype none

module pipeCtrlTop
    import pipeCtrlPkg::*;
(
    input  logic clk,
    input  logic rstN,
    // fetch
    input  logic fetchReq,
    input  addrT fetchAddr,
    output logic instrValid,
    output wordT instr,
    // load / store
    input  logic dataReq,
    input  logic dataWe,
    input  addrT dataAddr,
    input  wordT dataWdata,
    output logic loadValid,
    output wordT loadData,
    output logic doneStore,
    // execute and writeback events
    input  logic branchE,
    input  logic eWait,
    input  logic branchMisalign,
    input  logic excpW,
    // stall / flush
    output logic stallF,
    output logic stallF2,
    output logic stallD,
    output logic stallE,
    output logic stallM,
    output logic stallM2,
    output logic flushF2,
    output logic flushI,
    output logic flushD,
    output logic flushE,
    output logic flushM,
    output logic flushW,
    output logic flushQue,
    output logic iWait,
    output logic dWait
);
    // client to arbiter
    logic reqF;
    addrT addrF;
    logic grantF;
    logic rspF;
    logic reqD;
    logic weD;
    addrT addrD;
    wordT wdataD;
    logic grantD;
    logic rspD;
    // arbiter to memory
    logic memEn;
    logic memWe;
    addrT memAddr;
    wordT memWdata;
    wordT rdData;

    fetchPort fetchPort_i (
        .clk        (clk),
        .rstN       (rstN),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .instrValid (instrValid),
        .instr      (instr),
        .iWait      (iWait),
        .reqF       (reqF),
        .addrF      (addrF),
        .grantF     (grantF),
        .rspF       (rspF),
        .rspData    (rdData)
    );

    dataPort dataPort_i (
        .clk       (clk),
        .rstN      (rstN),
        .dataReq   (dataReq),
        .dataWe    (dataWe),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .loadValid (loadValid),
        .loadData  (loadData),
        .doneStore (doneStore),
        .dWait     (dWait),
        .reqD      (reqD),
        .weD       (weD),
        .addrD     (addrD),
        .wdataD    (wdataD),
        .grantD    (grantD),
        .rspD      (rspD),
        .rspData   (rdData)
    );

    memArbiter memArbiter_i (
        .clk      (clk),
        .rstN     (rstN),
        .reqF     (reqF),
        .addrF    (addrF),
        .reqD     (reqD),
        .weD      (weD),
        .addrD    (addrD),
        .wdataD   (wdataD),
        .grantF   (grantF),
        .grantD   (grantD),
        .memEn    (memEn),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .rspF     (rspF),
        .rspD     (rspD)
    );

    // read data fans out to both ports, the strobes pick the owner
    sharedMem sharedMem_i (
        .clk      (clk),
        .memEn    (memEn),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .rdData   (rdData)
    );

    hazardUnit hazardUnit_i (
        .clk            (clk),
        .rstN           (rstN),
        .branchE        (branchE),
        .iWait          (iWait),
        .dWait          (dWait),
        .eWait          (eWait),
        .branchMisalign (branchMisalign),
        .excpW          (excpW),
        .stallF         (stallF),
        .stallF2        (stallF2),
        .stallD         (stallD),
        .stallE         (stallE),
        .stallM         (stallM),
        .stallM2        (stallM2),
        .flushF2        (flushF2),
        .flushI         (flushI),
        .flushD         (flushD),
        .flushE         (flushE),
        .flushM         (flushM),
        .flushW         (flushW),
        .flushQue       (flushQue)
    );

endmodule

`default_nettype wire

/* src/pipeCtrl_settings.svh */
`ifndef PIPECTRL_SETTINGS_SVH
`define PIPECTRL_SETTINGS_SVH

// word address bits, one address per data word
`define ADDR_WIDTH 8

// data word bits
`define DATA_WIDTH 32

// memory words, covers the full address range
`define MEM_DEPTH 256

`endif

/* src/sharedMem.sv */
`default_nettype none

`include "pipeCtrl_settings.svh"

module sharedMem
    import pipeCtrlPkg::*;
(
    input  logic clk,
    input  logic memEn,
    input  logic memWe,
    input  addrT memAddr,
    input  wordT memWdata,
    output wordT rdData
);
    wordT mem [`MEM_DEPTH];

    // power-up contents are zero
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // single port, read data registered
    always_ff @(posedge clk) begin
        if (memEn) begin
            if (memWe) begin
                mem[memAddr] <= memWdata;
            end
            // on a write this returns the old word, nobody consumes it
            rdData <= mem[memAddr];
        end
    end

endmodule

`default_nettype wire

/* tb/pipeCtrlChecker.sv */
`default_nettype none

`include "pipeCtrl_settings.svh"

module pipeCtrlChecker
    import pipeCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        fetchReq,
    input  addrT        fetchAddr,
    input  logic        instrValid,
    input  wordT        instr,
    input  logic        dataReq,
    input  logic        dataWe,
    input  addrT        dataAddr,
    input  wordT        dataWdata,
    input  logic        loadValid,
    input  wordT        loadData,
    input  logic        doneStore,
    input  logic        branchE,
    input  logic        eWait,
    input  logic        branchMisalign,
    input  logic        excpW,
    input  logic        iWait,
    input  logic        dWait,
    // stall F F2 D E M M2, then flush F2 I D E M W Que
    input  logic [12:0] hazOut,
    output int          mismatchCount
);
    timeunit 1ns;
    timeprecision 100ps;

    int errors = 0;

    // own copy of the three fetch-pending bits
    logic excpPend;
    logic branchPend;
    logic misPend;
    // outstanding accesses as seen at the port inputs
    logic fPend;
    addrT fAddr;
    logic dPend;
    logic dWe;
    addrT dAddr;
    wordT dWdata;
    // fetch and data strobed in the same cycle, data must return first
    logic pairOpen;
    logic [12:0] expHaz;
    wordT memModel [`MEM_DEPTH];

    assign mismatchCount = errors;

    // expected stall and flush levels, same bit order as hazOut
    function automatic logic [12:0] expectHazard(
        input logic ex,
        input logic ew,
        input logic dw,
        input logic iw,
        input logic br,
        input logic mis,
        input logic pend
    );
        logic sF, sF2, sD, sE, sM;
        logic fF2, fI, fD, fE, fM, fW, fQ;
        {sF, sF2, sD, sE, sM} = '0;
        {fF2, fI, fD, fE, fM, fW, fQ} = '0;
        if (ex) begin
            // every stage flushed, fetch held while it is still out
            {fF2, fI, fD, fE, fM, fW, fQ} = '1;
            sF = iw;
        end else if (ew) begin
            {sF, sF2, sD, sE} = '1;
            sM = dw;
            fM = !dw;
        end else if (dw) begin
            {sF, sF2, sD, sE, sM} = '1;
        end else if (iw) begin
            sF  = 1'b1;
            fD  = 1'b1;
            fF2 = br;
            fI  = br;
            fE  = br;
            fM  = br;
            fQ  = br;
        end else begin
            fF2 = br || mis;
            fD  = br || mis;
            fI  = br;
            fE  = br;
            fM  = br;
            fQ  = br;
        end
        // returned fetch behind a pending event, decode dropped once
        if (!iw && pend) begin
            fD = 1'b1;
        end
        return {sF, sF2, sD, sE, sM, 1'b0, fF2, fI, fD, fE, fM, fW, fQ};
    endfunction

    task automatic reportMismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            excpPend   <= 1'b0;
            branchPend <= 1'b0;
            misPend    <= 1'b0;
            fPend      <= 1'b0;
            fAddr      <= '0;
            dPend      <= 1'b0;
            dWe        <= 1'b0;
            dAddr      <= '0;
            dWdata     <= '0;
            pairOpen   <= 1'b0;
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                memModel[i] <= '0;
            end
        end else begin
            expHaz = expectHazard(excpW, eWait, dWait, iWait, branchE, branchMisalign,
                                  excpPend || branchPend || misPend);
            if (hazOut !== expHaz) begin
                reportMismatch($sformatf("stall/flush %b, expected %b", hazOut, expHaz));
            end
            if (iWait !== (fPend && !instrValid)) begin
                reportMismatch($sformatf("iWait %b, fetch pending %b", iWait, fPend));
            end
            if (dWait !== (dPend && !(loadValid || doneStore))) begin
                reportMismatch($sformatf("dWait %b, data pending %b", dWait, dPend));
            end

            // pending bits, set only while a fetch is out
            if (excpW && iWait) begin
                excpPend <= 1'b1;
            end
            if (!excpW && !eWait && !dWait && iWait && branchE) begin
                branchPend <= 1'b1;
            end
            if (!excpW && !eWait && !dWait && iWait && branchMisalign) begin
                misPend <= 1'b1;
            end
            if (!iWait) begin
                excpPend   <= 1'b0;
                branchPend <= 1'b0;
                misPend    <= 1'b0;
            end

            // fetch return
            if (instrValid) begin
                if (!fPend) begin
                    reportMismatch("instrValid without an open fetch");
                end else if (instr !== memModel[fAddr]) begin
                    reportMismatch($sformatf("instr %h at %h, expected %h",
                                             instr, fAddr, memModel[fAddr]));
                end
                if (pairOpen && dPend) begin
                    reportMismatch("fetch returned before a data access strobed with it");
                end
                fPend    <= 1'b0;
                pairOpen <= 1'b0;
            end

            // data return, memory model follows completed stores
            if (loadValid || doneStore) begin
                if (!dPend) begin
                    reportMismatch("data response without an open access");
                end else if (doneStore !== dWe) begin
                    reportMismatch($sformatf("response kind store=%b, expected %b",
                                             doneStore, dWe));
                end else if (loadValid && loadData !== memModel[dAddr]) begin
                    reportMismatch($sformatf("load %h at %h, expected %h",
                                             loadData, dAddr, memModel[dAddr]));
                end
                if (doneStore) begin
                    memModel[dAddr] <= dWdata;
                end
                dPend    <= 1'b0;
                pairOpen <= 1'b0;
            end

            // strobes only taken when the port is idle
            if (fetchReq && !fPend) begin
                fPend <= 1'b1;
                fAddr <= fetchAddr;
            end
            if (dataReq && !dPend) begin
                dPend  <= 1'b1;
                dWe    <= dataWe;
                dAddr  <= dataAddr;
                dWdata <= dataWdata;
            end
            if (fetchReq && !fPend && dataReq && !dPend) begin
                pairOpen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/pipeCtrlTb.sv */
`default_nettype none

module pipeCtrlTb
    import pipeCtrlPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_CYCLES = 2000;
    localparam int WAIT_LIMIT = 50;

    logic clk;
    logic rstN;
    logic fetchReq;
    addrT fetchAddr;
    logic instrValid;
    wordT instr;
    logic dataReq;
    logic dataWe;
    addrT dataAddr;
    wordT dataWdata;
    logic loadValid;
    wordT loadData;
    logic doneStore;
    logic branchE;
    logic eWait;
    logic branchMisalign;
    logic excpW;
    logic stallF;
    logic stallF2;
    logic stallD;
    logic stallE;
    logic stallM;
    logic stallM2;
    logic flushF2;
    logic flushI;
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
    logic flushQue;
    logic iWait;
    logic dWait;
    logic [12:0] hazOut;

    logic [31:0] rngState;
    int cycleCount;
    int timeoutCount;
    int mismatchCount;
    logic aborted;
    logic idleInstr;
    logic idleData;
    // word addresses that already got a store
    addrT storedAddrs[$];

    // stall bits first, then flush bits
    assign hazOut = {stallF, stallF2, stallD, stallE, stallM, stallM2,
                     flushF2, flushI, flushD, flushE, flushM, flushW, flushQue};

    pipeCtrlTop pipeCtrlTop_i (
        .clk            (clk),
        .rstN           (rstN),
        .fetchReq       (fetchReq),
        .fetchAddr      (fetchAddr),
        .instrValid     (instrValid),
        .instr          (instr),
        .dataReq        (dataReq),
        .dataWe         (dataWe),
        .dataAddr       (dataAddr),
        .dataWdata      (dataWdata),
        .loadValid      (loadValid),
        .loadData       (loadData),
        .doneStore      (doneStore),
        .branchE        (branchE),
        .eWait          (eWait),
        .branchMisalign (branchMisalign),
        .excpW          (excpW),
        .stallF         (stallF),
        .stallF2        (stallF2),
        .stallD         (stallD),
        .stallE         (stallE),
        .stallM         (stallM),
        .stallM2        (stallM2),
        .flushF2        (flushF2),
        .flushI         (flushI),
        .flushD         (flushD),
        .flushE         (flushE),
        .flushM         (flushM),
        .flushW         (flushW),
        .flushQue       (flushQue),
        .iWait          (iWait),
        .dWait          (dWait)
    );

    pipeCtrlChecker pipeCtrlChecker_i (
        .clk            (clk),
        .rstN           (rstN),
        .fetchReq       (fetchReq),
        .fetchAddr      (fetchAddr),
        .instrValid     (instrValid),
        .instr          (instr),
        .dataReq        (dataReq),
        .dataWe         (dataWe),
        .dataAddr       (dataAddr),
        .dataWdata      (dataWdata),
        .loadValid      (loadValid),
        .loadData       (loadData),
        .doneStore      (doneStore),
        .branchE        (branchE),
        .eWait          (eWait),
        .branchMisalign (branchMisalign),
        .excpW          (excpW),
        .iWait          (iWait),
        .dWait          (dWait),
        .hazOut         (hazOut),
        .mismatchCount  (mismatchCount)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // xorshift32, state moves on every draw
    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // one clock, responses sampled on the edge, new inputs 2 ns later
    task automatic stepCycle(input logic quiet, output logic sawInstr, output logic sawData);
        logic [31:0] r;
        @(posedge clk);
        sawInstr = instrValid;
        sawData  = loadValid || doneStore;
        #2;
        cycleCount++;
        fetchReq = 1'b0;
        dataReq  = 1'b0;
        r = nextRandom();
        // exceptions and branches rare, execute wait somewhat more often
        excpW          = !quiet && (r[7:0] < 8'd5);
        branchE        = !quiet && (r[15:8] < 8'd18);
        branchMisalign = !quiet && (r[23:16] < 8'd8);
        eWait          = !quiet && (r[31:24] < 8'd36);
    endtask

    // bounded wait for the requested responses
    task automatic waitResponses(input logic wantInstr, input logic wantData);
        logic gotInstr;
        logic gotData;
        logic sawInstr;
        logic sawData;
        int waited;
        gotInstr = !wantInstr;
        gotData  = !wantData;
        waited   = 0;
        while (!(gotInstr && gotData) && waited < WAIT_LIMIT) begin
            stepCycle(1'b0, sawInstr, sawData);
            gotInstr = gotInstr || sawInstr;
            gotData  = gotData || sawData;
            waited++;
        end
        if (!(gotInstr && gotData)) begin
            $display("Timeout at %0t: memory response did not arrive within %0d cycles",
                     $time, WAIT_LIMIT);
            timeoutCount++;
            aborted = 1'b1;
        end
    endtask

    // idle gap, lone fetch, lone data access, or both strobed together
    task automatic runTransaction();
        logic [31:0] r;
        logic sawInstr;
        logic sawData;
        logic doFetch;
        logic doData;
        int idx;
        r = nextRandom();
        doFetch = r[0];
        doData  = r[1];
        if (!doFetch && !doData) begin
            repeat (int'(r[4:2]) + 1) begin
                stepCycle(1'b0, sawInstr, sawData);
            end
        end else begin
            if (doFetch) begin
                fetchReq  = 1'b1;
                fetchAddr = {2'b00, r[13:8]};
            end
            if (doData) begin
                dataReq = 1'b1;
                // loads only revisit words that were stored before
                if (storedAddrs.size() == 0 || r[2]) begin
                    dataWe    = 1'b1;
                    dataAddr  = {3'b000, r[20:16]};
                    dataWdata = nextRandom();
                    storedAddrs.push_back(dataAddr);
                end else begin
                    idx      = int'(r[31:24]) % storedAddrs.size();
                    dataWe   = 1'b0;
                    dataAddr = storedAddrs[idx];
                end
            end
            waitResponses(doFetch, doData);
        end
    endtask

    initial begin
        rngState       = 32'h464;
        cycleCount     = 0;
        timeoutCount   = 0;
        aborted        = 1'b0;
        rstN           = 1'b0;
        fetchReq       = 1'b0;
        fetchAddr      = '0;
        dataReq        = 1'b0;
        dataWe         = 1'b0;
        dataAddr       = '0;
        dataWdata      = '0;
        branchE        = 1'b0;
        eWait          = 1'b0;
        branchMisalign = 1'b0;
        excpW          = 1'b0;
        repeat (5) begin
            @(posedge clk);
        end
        #2;
        rstN = 1'b1;
        // quiet cycles right after reset, all outputs low
        repeat (4) begin
            stepCycle(1'b1, idleInstr, idleData);
        end
        while (cycleCount < RUN_CYCLES && !aborted) begin
            runTransaction();
        end
        // let leftover pending bits drain
        repeat (4) begin
            stepCycle(1'b1, idleInstr, idleData);
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
